// ==== cacheArray.sv ====
////////////////////////////////////////////////////////////////////////////
// Direct-mapped cache arrays
// Tag, valid and line storage with load read, store commit and fill
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cacheArray (
  input  logic                 clk,
  input  logic                 reset,
  input  dcachePkg::addrT      ldAddr_i,
  input  logic                 headCommit_i,
  input  dcachePkg::stbCommitT stbHead_i,
  input  logic                 fillValid_i,
  input  dcachePkg::memFillT   fill_i,
  output logic                 cacheHit_o,
  output dcachePkg::dataT      cacheWord_o,
  output logic                 stMiss_o
);

  dcachePkg::tagT  tagArr  [dcachePkg::NumLines];
  dcachePkg::lineT dataArr [dcachePkg::NumLines];
  logic [dcachePkg::NumLines-1:0] validArr;

  // Load fields
  dcachePkg::tagT     ldTag;
  dcachePkg::indexT   ldIdx;
  dcachePkg::wordOffT ldWord;
  dcachePkg::lineT    ldLine;

  // Store buffer head fields
  dcachePkg::tagT     headTag;
  dcachePkg::indexT   headIdx;
  dcachePkg::wordOffT headWord;
  dcachePkg::lineT    mergedLine;
  logic               commitHit;
  logic               fillSameIdx;

  assign ldTag  = ldAddr_i[dcachePkg::AddrBits-1 -: dcachePkg::TagBits];
  assign ldIdx  = ldAddr_i[dcachePkg::ByteOffBits+dcachePkg::WordOffBits +: dcachePkg::IndexBits];
  assign ldWord = ldAddr_i[dcachePkg::ByteOffBits +: dcachePkg::WordOffBits];

  // Combinational read for same-cycle load answer
  assign ldLine      = dataArr[ldIdx];
  assign cacheHit_o  = validArr[ldIdx] & (tagArr[ldIdx] == ldTag);
  assign cacheWord_o = ldLine[ldWord*dcachePkg::DataBits +: dcachePkg::DataBits];

  assign headTag  = stbHead_i.addr[dcachePkg::AddrBits-1 -: dcachePkg::TagBits];
  assign headIdx  = stbHead_i.addr[dcachePkg::ByteOffBits+dcachePkg::WordOffBits +:
                                   dcachePkg::IndexBits];
  assign headWord = stbHead_i.addr[dcachePkg::ByteOffBits +: dcachePkg::WordOffBits];

  assign commitHit   = headCommit_i & validArr[headIdx] & (tagArr[headIdx] == headTag);
  assign stMiss_o    = headCommit_i & ~commitHit;
  assign fillSameIdx = fillValid_i & (fill_i.index == headIdx);

  // Merge enabled bytes of the head store into its line
  always_comb
  begin
    mergedLine = dataArr[headIdx];
    for (int b = 0; b < dcachePkg::DataBytes; b++)
    begin
      if (stbHead_i.byteEn[b])
        mergedLine[int'(headWord)*dcachePkg::DataBits + b*8 +: 8] = stbHead_i.data[b*8 +: 8];
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      validArr <= '0;
    else if (fillValid_i)
      validArr[fill_i.index] <= 1'b1;
  end

  // Fill overrides a commit to the same index
  always_ff @(posedge clk)
  begin
    if (commitHit && !fillSameIdx)
      dataArr[headIdx] <= mergedLine;
    if (fillValid_i)
    begin
      dataArr[fill_i.index] <= fill_i.data;
      tagArr[fill_i.index]  <= fill_i.tag;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    (headCommit_i && fillSameIdx) |=> (dataArr[$past(headIdx)] == $past(fill_i.data)));

endmodule

// ==== dcachePkg.sv ====
////////////////////////////////////////////////////////////////////////////
// L1 data cache shared definitions
// Widths, address field types, access size encodings and port structs
// for the write-through direct-mapped data cache
////////////////////////////////////////////////////////////////////////////

package dcachePkg;

  // Address and data geometry
  localparam int AddrBits    = 32;
  localparam int DataBits    = 64;
  localparam int DataBytes   = 8;
  localparam int ByteOffBits = 3;
  localparam int WordsInLine = 4;
  localparam int WordOffBits = 2;
  localparam int IndexBits   = 6;
  localparam int NumLines    = 64;
  localparam int TagBits     = 21;
  localparam int LineBits    = 256;

  // Store buffer
  localparam int StbDepth   = 8;
  localparam int StbPtrBits = 3;

  typedef logic [AddrBits-1:0]    addrT;
  typedef logic [DataBits-1:0]    dataT;
  typedef logic [DataBytes-1:0]   byteEnT;
  typedef logic [TagBits-1:0]     tagT;
  typedef logic [IndexBits-1:0]   indexT;
  typedef logic [WordOffBits-1:0] wordOffT;
  typedef logic [LineBits-1:0]    lineT;
  typedef logic [StbPtrBits-1:0]  stbPtrT;

  // Order matters, forwarding compares sizes numerically
  typedef enum logic [1:0] {
    BYTE   = 2'd0,
    HALF   = 2'd1,
    WORD   = 2'd2,
    DOUBLE = 2'd3
  } ldStSizeT;

  // Size code carried by the memory store message
  typedef enum logic [2:0] {
    MEM1B = 3'd1,
    MEM2B = 3'd2,
    MEM4B = 3'd3,
    MEM8B = 3'd4
  } memSizeT;

  typedef struct packed {
    addrT     addr;
    ldStSizeT size;
    logic     sign;
  } ldReqT;

  typedef struct packed {
    addrT     addr;
    ldStSizeT size;
    dataT     data;
  } stReqT;

  typedef struct packed {
    addrT    addr;
    dataT    data;
    memSizeT size;
  } memStReqT;

  typedef struct packed {
    tagT   tag;
    indexT index;
    lineT  data;
  } memFillT;

  typedef struct packed {
    logic hit;
    logic partial;
    dataT data;
  } stbFwdT;

  typedef struct packed {
    addrT   addr;
    byteEnT byteEn;
    dataT   data;
  } stbCommitT;

endpackage

// ==== dcacheTop.sv ====
////////////////////////////////////////////////////////////////////////////
// Write-through L1 data cache controller
// Store buffer, cache arrays, miss handler and load alignment
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcacheTop (
  input  logic                clk,
  input  logic                reset,
  input  logic                ldEn_i,
  input  dcachePkg::ldReqT    ldReq_i,
  input  logic                stEn_i,
  input  dcachePkg::stReqT    stReq_i,
  input  logic                mem2dcLdValid_i,
  input  dcachePkg::memFillT  mem2dcLd_i,
  input  logic                mem2dcStComplete_i,
  input  logic                mem2dcStStall_i,
  output dcachePkg::dataT     ldData_o,
  output logic                ldHit_o,
  output logic                ldMiss_o,
  output logic                dc2memLdValid_o,
  output logic [dcachePkg::TagBits+dcachePkg::IndexBits-1:0] dc2memLdAddr_o,
  output logic                dc2memStValid_o,
  output dcachePkg::memStReqT dc2memSt_o,
  output logic                stallStCommit_o,
  output logic                stbEmpty_o,
  output logic                stMiss_o
);

  // Store buffer to load path and arrays
  dcachePkg::stbFwdT    stbFwd;
  logic                 headCommit;
  dcachePkg::stbCommitT stbHead;

  // Array read result
  logic                 cacheHit;
  dcachePkg::dataT      cacheWord;

  // Qualified fill
  logic                 fillValid;
  dcachePkg::memFillT   fill;

  storeBuffer uStoreBuffer (
    .clk             (clk),
    .reset           (reset),
    .stEn_i          (stEn_i),
    .stReq_i         (stReq_i),
    .stComplete_i    (mem2dcStComplete_i),
    .memStall_i      (mem2dcStStall_i),
    .ldReq_i         (ldReq_i),
    .dc2memStValid_o (dc2memStValid_o),
    .dc2memSt_o      (dc2memSt_o),
    .stbFwd_o        (stbFwd),
    .headCommit_o    (headCommit),
    .stbHead_o       (stbHead),
    .stallStCommit_o (stallStCommit_o),
    .stbEmpty_o      (stbEmpty_o)
  );

  cacheArray uCacheArray (
    .clk          (clk),
    .reset        (reset),
    .ldAddr_i     (ldReq_i.addr),
    .headCommit_i (headCommit),
    .stbHead_i    (stbHead),
    .fillValid_i  (fillValid),
    .fill_i       (fill),
    .cacheHit_o   (cacheHit),
    .cacheWord_o  (cacheWord),
    .stMiss_o     (stMiss_o)
  );

  missHandler uMissHandler (
    .clk             (clk),
    .reset           (reset),
    .ldEn_i          (ldEn_i),
    .ldAddr_i        (ldReq_i.addr),
    .ldHit_i         (ldHit_o),
    .mem2dcLdValid_i (mem2dcLdValid_i),
    .mem2dcLd_i      (mem2dcLd_i),
    .ldMiss_o        (ldMiss_o),
    .dc2memLdValid_o (dc2memLdValid_o),
    .dc2memLdAddr_o  (dc2memLdAddr_o),
    .fillValid_o     (fillValid),
    .fill_o          (fill)
  );

  loadAlign uLoadAlign (
    .ldEn_i      (ldEn_i),
    .ldReq_i     (ldReq_i),
    .stbFwd_i    (stbFwd),
    .cacheHit_i  (cacheHit),
    .cacheWord_i (cacheWord),
    .ldHit_o     (ldHit_o),
    .ldData_o    (ldData_o)
  );

endmodule

// ==== loadAlign.sv ====
////////////////////////////////////////////////////////////////////////////
// Load result selection
// Picks forwarded or cached word, qualifies the hit, aligns and extends
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module loadAlign (
  input  logic              ldEn_i,
  input  dcachePkg::ldReqT  ldReq_i,
  input  dcachePkg::stbFwdT stbFwd_i,
  input  logic              cacheHit_i,
  input  dcachePkg::dataT   cacheWord_i,
  output logic              ldHit_o,
  output dcachePkg::dataT   ldData_o
);

  dcachePkg::dataT word;
  dcachePkg::dataT shifted;
  logic [dcachePkg::ByteOffBits-1:0] off;

  // Buffered store is newer than the cache line
  assign word = stbFwd_i.hit ? stbFwd_i.data : cacheWord_i;
  assign off  = ldReq_i.addr[dcachePkg::ByteOffBits-1:0];

  // Partial overlap forces a replay
  assign ldHit_o = ldEn_i & (stbFwd_i.hit | cacheHit_i) & ~stbFwd_i.partial;

  always_comb
  begin
    shifted  = word;
    ldData_o = word;
    case (ldReq_i.size)
      dcachePkg::BYTE:
      begin
        shifted  = word >> {off, 3'b000};
        ldData_o = {{(dcachePkg::DataBits-8){ldReq_i.sign & shifted[7]}}, shifted[7:0]};
      end
      dcachePkg::HALF:
      begin
        shifted  = word >> {off[2:1], 4'h0};
        ldData_o = {{(dcachePkg::DataBits-16){ldReq_i.sign & shifted[15]}}, shifted[15:0]};
      end
      dcachePkg::WORD:
      begin
        shifted  = word >> {off[2], 5'h00};
        ldData_o = {{(dcachePkg::DataBits-32){ldReq_i.sign & shifted[31]}}, shifted[31:0]};
      end
      default:
      begin
        // Double word needs no shift
      end
    endcase
  end

endmodule

// ==== missHandler.sv ====
////////////////////////////////////////////////////////////////////////////
// Single-entry miss handler
// Turns load misses into one line request and qualifies the returned fill
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module missHandler (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ldEn_i,
  input  dcachePkg::addrT      ldAddr_i,
  input  logic                 ldHit_i,
  input  logic                 mem2dcLdValid_i,
  input  dcachePkg::memFillT   mem2dcLd_i,
  output logic                 ldMiss_o,
  output logic                 dc2memLdValid_o,
  output logic [dcachePkg::TagBits+dcachePkg::IndexBits-1:0] dc2memLdAddr_o,
  output logic                 fillValid_o,
  output dcachePkg::memFillT   fill_o
);

  dcachePkg::tagT   ldTag;
  dcachePkg::indexT ldIdx;
  dcachePkg::tagT   ldTagQ;
  dcachePkg::indexT ldIdxQ;

  // MSHR state
  logic             mshrValid;
  dcachePkg::tagT   mshrTag;
  dcachePkg::indexT mshrIdx;

  logic missD1;
  logic missD2;
  logic missPulse;
  logic fillMatch;
  logic fillSameLd;
  logic fillOther;

  assign ldTag = ldAddr_i[dcachePkg::AddrBits-1 -: dcachePkg::TagBits];
  assign ldIdx = ldAddr_i[dcachePkg::ByteOffBits+dcachePkg::WordOffBits +: dcachePkg::IndexBits];

  assign ldMiss_o = ldEn_i & ~ldHit_i;

  // A fill landing now makes the next replay hit, so no new miss
  assign fillSameLd = fillValid_o & (fill_o.tag == ldTag) & (fill_o.index == ldIdx);
  assign missPulse  = missD1 & ~missD2;
  // MSHR frees this cycle for some other line
  assign fillOther  = fillValid_o & ({fill_o.tag, fill_o.index} != {ldTagQ, ldIdxQ});

  assign dc2memLdValid_o = missPulse & (~mshrValid | fillOther);
  assign dc2memLdAddr_o  = {ldTagQ, ldIdxQ};

  assign fillMatch = mem2dcLdValid_i & mshrValid &
                     (mem2dcLd_i.tag == mshrTag) & (mem2dcLd_i.index == mshrIdx);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      missD1      <= 1'b0;
      missD2      <= 1'b0;
      mshrValid   <= 1'b0;
      fillValid_o <= 1'b0;
    end
    else
    begin
      missD1      <= ldMiss_o & ~fillSameLd;
      // Drop on a fill so a waiting miss pulses again
      missD2      <= missD1 & ~fillValid_o;
      fillValid_o <= fillMatch;
      if (dc2memLdValid_o)
        mshrValid <= 1'b1;
      else if (fillValid_o)
        mshrValid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    ldTagQ <= ldTag;
    ldIdxQ <= ldIdx;
    if (dc2memLdValid_o)
    begin
      mshrTag <= ldTagQ;
      mshrIdx <= ldIdxQ;
    end
    if (fillMatch)
      fill_o <= mem2dcLd_i;
  end

  assert property (@(posedge clk) disable iff (reset) fillValid_o |-> $past(mshrValid));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbDcache -f src.f -o simDcache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simDcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== src.f ====
dcachePkg.sv
storeBuffer.sv
cacheArray.sv
missHandler.sv
loadAlign.sv
dcacheTop.sv
tbMemModel.sv
tbDcache.sv

// ==== storeBuffer.sv ====
////////////////////////////////////////////////////////////////////////////
// Store buffer
// Aligns stores, queues them in an 8-entry ring, issues the write-through
// message and forwards buffered data to loads
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module storeBuffer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stEn_i,
  input  dcachePkg::stReqT     stReq_i,
  input  logic                 stComplete_i,
  input  logic                 memStall_i,
  input  dcachePkg::ldReqT     ldReq_i,
  output logic                 dc2memStValid_o,
  output dcachePkg::memStReqT  dc2memSt_o,
  output dcachePkg::stbFwdT    stbFwd_o,
  output logic                 headCommit_o,
  output dcachePkg::stbCommitT stbHead_o,
  output logic                 stallStCommit_o,
  output logic                 stbEmpty_o
);

  // Aligned store and memory payload
  dcachePkg::dataT    alignData;
  dcachePkg::byteEnT  alignEn;
  dcachePkg::dataT    memData;
  dcachePkg::memSizeT memSize;
  logic [dcachePkg::ByteOffBits-1:0] stOff;

  // Queue storage
  dcachePkg::addrT     entAddr   [dcachePkg::StbDepth];
  dcachePkg::ldStSizeT entSize   [dcachePkg::StbDepth];
  dcachePkg::dataT     entData   [dcachePkg::StbDepth];
  dcachePkg::byteEnT   entByteEn [dcachePkg::StbDepth];
  logic [dcachePkg::StbDepth-1:0] entValid;

  dcachePkg::stbPtrT head;
  dcachePkg::stbPtrT tail;
  dcachePkg::stbPtrT scanIdx;
  logic              full;
  logic              completeQ;

  assign stOff = stReq_i.addr[dcachePkg::ByteOffBits-1:0];

  always_comb
  begin
    alignData = stReq_i.data;
    alignEn   = '1;
    memData   = stReq_i.data;
    memSize   = dcachePkg::MEM8B;
    case (stReq_i.size)
      dcachePkg::BYTE:
      begin
        alignData = stReq_i.data << {stOff, 3'b000};
        alignEn   = dcachePkg::byteEnT'(8'h01) << stOff;
        memData   = {8{stReq_i.data[7:0]}};
        memSize   = dcachePkg::MEM1B;
      end
      dcachePkg::HALF:
      begin
        alignData = stReq_i.data << {stOff[2:1], 4'h0};
        alignEn   = dcachePkg::byteEnT'(8'h03) << {stOff[2:1], 1'b0};
        memData   = {4{stReq_i.data[15:0]}};
        memSize   = dcachePkg::MEM2B;
      end
      dcachePkg::WORD:
      begin
        alignData = stReq_i.data << {stOff[2], 5'h00};
        alignEn   = stOff[2] ? 8'hF0 : 8'h0F;
        memData   = {2{stReq_i.data[31:0]}};
        memSize   = dcachePkg::MEM4B;
      end
      default:
      begin
        // Double word goes through as is
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Queue pointers and write-through message
  ////////////////////////////////////////////////////////////////////////////

  assign full            = (head == tail) & entValid[head];
  assign stbEmpty_o      = (head == tail) & ~entValid[head];
  assign stallStCommit_o = full | memStall_i;

  // Completion is registered, pop happens the cycle after
  assign headCommit_o = completeQ;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      head            <= '0;
      tail            <= '0;
      entValid        <= '0;
      completeQ       <= 1'b0;
      dc2memStValid_o <= 1'b0;
    end
    else
    begin
      completeQ       <= stComplete_i;
      dc2memStValid_o <= stEn_i;
      if (stEn_i)
      begin
        entValid[tail] <= 1'b1;
        tail <= (tail == dcachePkg::StbPtrBits'(dcachePkg::StbDepth - 1)) ? '0 : tail + 1'b1;
      end
      if (completeQ)
      begin
        entValid[head] <= 1'b0;
        head <= (head == dcachePkg::StbPtrBits'(dcachePkg::StbDepth - 1)) ? '0 : head + 1'b1;
      end
    end
  end

  // Entry payload and memory message
  always_ff @(posedge clk)
  begin
    if (stEn_i)
    begin
      entAddr[tail]   <= stReq_i.addr;
      entSize[tail]   <= stReq_i.size;
      entData[tail]   <= alignData;
      entByteEn[tail] <= alignEn;
    end
    dc2memSt_o.addr <= stReq_i.addr;
    dc2memSt_o.data <= memData;
    dc2memSt_o.size <= memSize;
  end

  assign stbHead_o.addr   = entAddr[head];
  assign stbHead_o.byteEn = entByteEn[head];
  assign stbHead_o.data   = entData[head];

  ////////////////////////////////////////////////////////////////////////////
  // Load forwarding
  ////////////////////////////////////////////////////////////////////////////

  // Walk oldest to newest, the last word match decides
  always_comb
  begin
    stbFwd_o = '0;
    scanIdx  = head;
    for (int i = 0; i < dcachePkg::StbDepth; i++)
    begin
      scanIdx = head + dcachePkg::stbPtrT'(i);
      if (entValid[scanIdx] &&
          entAddr[scanIdx][dcachePkg::AddrBits-1:dcachePkg::ByteOffBits] ==
          ldReq_i.addr[dcachePkg::AddrBits-1:dcachePkg::ByteOffBits])
      begin
        stbFwd_o.hit = (entAddr[scanIdx][dcachePkg::ByteOffBits-1:0] ==
                        ldReq_i.addr[dcachePkg::ByteOffBits-1:0]) &&
                       (ldReq_i.size <= entSize[scanIdx]);
        // Same word but not fully covered
        stbFwd_o.partial = ~stbFwd_o.hit;
        stbFwd_o.data    = entData[scanIdx];
      end
    end
  end

  // Caller must honor the stall while the ring is full
  assert property (@(posedge clk) disable iff (reset) full |-> !stEn_i);

endmodule

// ==== tbDcache.sv ====
////////////////////////////////////////////////////////////////////////////
// Data cache testbench
// Miss and replay, forwarding, partial overlap, write-through, stall
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tbDcache;

  localparam logic [20:0] Tag = 21'h0A5C3;
  // Limit well above the few hundred cycles the tests need
  localparam int WatchdogCycles = 4000;

  logic clk;
  logic reset;
  logic ldEn;
  logic stEn;
  logic hold;
  dcachePkg::ldReqT    ldReq;
  dcachePkg::stReqT    stReq;
  logic                memFillValid;
  dcachePkg::memFillT  memFill;
  logic                stComplete;
  dcachePkg::dataT     ldData;
  logic                ldHit;
  logic                ldMiss;
  logic                ldReqValid;
  logic [26:0]         ldReqAddr;
  logic                stValid;
  dcachePkg::memStReqT stMsg;
  logic                stall;
  logic                stbEmpty;
  logic                stMiss;

  int errCount;
  int checkCount;

  dcacheTop uut (
    .clk(clk), .reset(reset), .ldEn_i(ldEn), .ldReq_i(ldReq), .stEn_i(stEn),
    .stReq_i(stReq), .mem2dcLdValid_i(memFillValid), .mem2dcLd_i(memFill),
    .mem2dcStComplete_i(stComplete), .mem2dcStStall_i(1'b0), .ldData_o(ldData),
    .ldHit_o(ldHit), .ldMiss_o(ldMiss), .dc2memLdValid_o(ldReqValid),
    .dc2memLdAddr_o(ldReqAddr), .dc2memStValid_o(stValid), .dc2memSt_o(stMsg),
    .stallStCommit_o(stall), .stbEmpty_o(stbEmpty), .stMiss_o(stMiss)
  );

  tbMemModel #(.BaseTag(Tag)) mem (
    .clk(clk), .reset(reset), .holdComplete_i(hold), .ldReqValid_i(ldReqValid),
    .ldReqAddr_i(ldReqAddr), .stValid_i(stValid), .st_i(stMsg),
    .fillValid_o(memFillValid), .fill_o(memFill), .stComplete_o(stComplete)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [63:0] exp, input logic [63:0] act);
    checkCount++;
    assert (exp === act)
    else
    begin
      errCount++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  function automatic logic [7:0] patByte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
  endfunction

  // Initial memory word holding this address
  function automatic dcachePkg::dataT patWord(input dcachePkg::addrT a);
    dcachePkg::dataT w;
    for (int k = 0; k < 8; k++)
      w[k*8 +: 8] = patByte({a[31:3], 3'(k)});
    return w;
  endfunction

  // Takes size bytes from the offset and extends them
  function automatic dcachePkg::dataT expLoad(input dcachePkg::addrT a, input logic [1:0] sz,
                                              input logic sgn, input dcachePkg::dataT word);
    int nBytes;
    int lo;
    dcachePkg::dataT r;
    nBytes = 1 << sz;
    lo     = int'(a[2:0]);
    r      = '0;
    for (int k = 0; k < nBytes; k++)
      r[k*8 +: 8] = word[(lo + k)*8 +: 8];
    if (sgn && r[nBytes*8-1])
      for (int k = nBytes*8; k < 64; k++)
        r[k] = 1'b1;
    return r;
  endfunction

  task automatic driveLoad(input dcachePkg::addrT a, input dcachePkg::ldStSizeT sz,
                           input logic sgn);
    ldEn       = 1'b1;
    ldReq.addr = a;
    ldReq.size = sz;
    ldReq.sign = sgn;
  endtask

  task automatic driveStore(input dcachePkg::addrT a, input dcachePkg::ldStSizeT sz,
                            input dcachePkg::dataT d);
    stEn       = 1'b1;
    stReq.addr = a;
    stReq.size = sz;
    stReq.data = d;
  endtask

  initial
  begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    dcachePkg::addrT addrA;
    dcachePkg::addrT addrB;
    dcachePkg::addrT addrC;
    dcachePkg::addrT addrW;
    dcachePkg::dataT dataB;
    dcachePkg::dataT merged;
    int reqCount;
    int waited;
    errCount   = 0;
    checkCount = 0;
    reset      = 1'b1;
    ldEn       = 1'b0;
    stEn       = 1'b0;
    hold       = 1'b1;
    ldReq      = '0;
    stReq      = '0;
    addrA = {Tag, 6'd5, 2'd2, 3'd4};
    addrB = {Tag, 6'd5, 2'd1, 3'd0};
    addrC = {Tag, 6'd5, 2'd3, 3'd1};
    addrW = {Tag, 6'd5, 2'd3, 3'd0};
    dataB = 64'h8123_4567_89ab_cdef;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    #1;

    // Reset state
    checkValue("reset ldReqValid", 0, ldReqValid);
    checkValue("reset stValid", 0, stValid);
    checkValue("reset ldHit", 0, ldHit);
    checkValue("reset stMiss", 0, stMiss);
    checkValue("reset stall", 0, stall);
    checkValue("reset stbEmpty", 1, stbEmpty);

    // Cold miss raises one request and replays until hit
    @(negedge clk);
    driveLoad(addrA, dcachePkg::WORD, 1'b1);
    #1;
    checkValue("miss hit", 0, ldHit);
    checkValue("miss flag", 1, ldMiss);
    checkValue("miss early request", 0, ldReqValid);
    @(negedge clk);
    #1;
    checkValue("miss request", 1, ldReqValid);
    checkValue("miss request addr", {Tag, 6'd5}, ldReqAddr);
    reqCount = 1;
    waited   = 0;
    while (!ldHit && waited < 200)
    begin
      @(negedge clk);
      #1;
      if (ldReqValid)
        reqCount++;
      waited++;
    end
    if (!ldHit)
    begin
      errCount++;
      $display("Replayed load never hit after the line request");
    end
    checkValue("miss data", expLoad(addrA, dcachePkg::WORD, 1'b1, patWord(addrA)), ldData);
    checkValue("miss request count", 1, reqCount);

    // Forwarding from a buffered double store
    @(negedge clk);
    ldEn = 1'b0;
    driveStore(addrB, dcachePkg::DOUBLE, dataB);
    @(negedge clk);
    stEn = 1'b0;
    driveLoad(addrB, dcachePkg::WORD, 1'b1);
    #1;
    checkValue("wt double valid", 1, stValid);
    checkValue("wt double addr", addrB, stMsg.addr);
    checkValue("wt double data", dataB, stMsg.data);
    checkValue("wt double size", 4, stMsg.size);
    checkValue("fwd word hit", 1, ldHit);
    checkValue("fwd word data", expLoad(addrB, dcachePkg::WORD, 1'b1, dataB), ldData);
    @(negedge clk);
    driveLoad(addrB, dcachePkg::DOUBLE, 1'b0);
    #1;
    checkValue("fwd double hit", 1, ldHit);
    checkValue("fwd double data", dataB, ldData);

    // Partial overlap with a buffered byte store
    @(negedge clk);
    ldEn = 1'b0;
    driveStore(addrC, dcachePkg::BYTE, 64'h9C);
    @(negedge clk);
    stEn = 1'b0;
    driveLoad(addrC, dcachePkg::HALF, 1'b0);
    #1;
    checkValue("wt byte data", {8{8'h9C}}, stMsg.data);
    checkValue("wt byte size", 1, stMsg.size);
    checkValue("partial larger hit", 0, ldHit);
    @(negedge clk);
    driveLoad(addrW, dcachePkg::BYTE, 1'b0);
    #1;
    checkValue("partial offset hit", 0, ldHit);
    @(negedge clk);
    driveLoad(addrC, dcachePkg::BYTE, 1'b0);
    #1;
    checkValue("fwd byte hit", 1, ldHit);
    checkValue("fwd byte data", 64'h9C, ldData);

    // Completions commit into the cached line
    @(negedge clk);
    ldEn   = 1'b0;
    hold   = 1'b0;
    waited = 0;
    while (!stbEmpty && waited < 200)
    begin
      @(negedge clk);
      #1;
      checkValue("commit stMiss", 0, stMiss);
      waited++;
    end
    if (!stbEmpty)
    begin
      errCount++;
      $display("Store buffer did not drain after completions");
    end
    @(negedge clk);
    driveLoad(addrB, dcachePkg::DOUBLE, 1'b0);
    #1;
    checkValue("merged double hit", 1, ldHit);
    checkValue("merged double data", dataB, ldData);
    merged        = patWord(addrW);
    merged[15:8]  = 8'h9C;
    @(negedge clk);
    driveLoad(addrW, dcachePkg::DOUBLE, 1'b0);
    #1;
    checkValue("merged byte hit", 1, ldHit);
    checkValue("merged byte data", merged, ldData);

    // Back-pressure with completions held
    @(negedge clk);
    ldEn = 1'b0;
    hold = 1'b1;
    for (int i = 0; i < 8; i++)
    begin
      driveStore({Tag, 6'd9, 2'(i), 3'd0}, dcachePkg::DOUBLE, 64'(i));
      #1;
      checkValue("fill stall", 0, stall);
      @(negedge clk);
    end
    stEn = 1'b0;
    #1;
    checkValue("full stall", 1, stall);
    hold   = 1'b0;
    waited = 0;
    while (stall && waited < 100)
    begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (stall)
    begin
      errCount++;
      $display("Stall stayed high after completions resumed");
    end
    checkValue("stall release not empty", 0, stbEmpty);
    @(negedge clk);

    $display("Checks run %0d, errors %0d", checkCount, errCount);
    if (errCount == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== tbMemModel.sv ====
////////////////////////////////////////////////////////////////////////////
// Backing memory for the data cache testbench
// Answers line requests after an LFSR delay, applies store messages and
// returns store completions
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tbMemModel #(
  parameter logic [20:0] BaseTag = 21'h0
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                holdComplete_i,
  input  logic                ldReqValid_i,
  input  logic [26:0]         ldReqAddr_i,
  input  logic                stValid_i,
  input  dcachePkg::memStReqT st_i,
  output logic                fillValid_o,
  output dcachePkg::memFillT  fill_o,
  output logic                stComplete_o
);

  dcachePkg::lineT lines [dcachePkg::NumLines];
  logic [26:0]     reqAddr;
  logic [31:0]     lfsr;
  logic            busy;
  int              waitCnt;
  int              pending;
  int              cdown;

  // Pattern byte mixes every address byte
  function automatic logic [7:0] patByte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic stepLfsr();
    logic nb;
    nb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], nb};
    return nb;
  endfunction

  initial
  begin
    for (int i = 0; i < dcachePkg::NumLines; i++)
      for (int b = 0; b < 32; b++)
        lines[i][b*8 +: 8] = patByte({BaseTag, 6'(i), 5'(b)});
  end

  always @(negedge clk or posedge reset)
  begin
    if (reset)
    begin
      lfsr         = 32'hf0032e8b;
      busy         = 1'b0;
      waitCnt      = 0;
      pending      = 0;
      cdown        = 3;
      fillValid_o  <= 1'b0;
      fill_o       <= '0;
      stComplete_o <= 1'b0;
    end
    else
    begin
      fillValid_o  <= 1'b0;
      stComplete_o <= 1'b0;
      // Store message, bytes picked from the replicated payload
      if (stValid_i && st_i.addr[31:11] == BaseTag)
      begin
        int n;
        int base;
        n    = 1 << (int'(st_i.size) - 1);
        base = int'(st_i.addr[2:0]) & ~(n - 1);
        for (int k = 0; k < 8; k++)
          if (k >= base && k < base + n)
            lines[st_i.addr[10:5]][int'(st_i.addr[4:3])*64 + k*8 +: 8] = st_i.data[k*8 +: 8];
      end
      if (stValid_i)
        pending++;
      // Completions in order, a few cycles apart
      if (pending > 0 && !holdComplete_i)
      begin
        if (cdown == 0)
        begin
          stComplete_o <= 1'b1;
          pending--;
          cdown = 3;
        end
        else
          cdown--;
      end
      // Line answer
      if (busy)
      begin
        if (waitCnt == 0)
        begin
          fillValid_o <= 1'b1;
          fill_o      <= {reqAddr[26:6], reqAddr[5:0], lines[reqAddr[5:0]]};
          busy = 1'b0;
        end
        else
          waitCnt--;
      end
      if (ldReqValid_i)
      begin
        reqAddr = ldReqAddr_i;
        busy    = 1'b1;
        waitCnt = 2 + {stepLfsr(), stepLfsr(), stepLfsr()};
      end
    end
  end

endmodule
